/* hdl/soc_macros.svh */
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

`default_nettype none

// Wishbone widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

// Lowest address bit of the 4-bit page field
`define IO_PAGE_LSB 12

// Peripheral pages
`define SEG_PAGE   0
`define TIMER_PAGE 8

// Timer word offsets, compare channel n at TMR_CMP0 + n
`define TMR_CTRL   0
`define TMR_STATUS 1
`define TMR_COUNT  2
`define TMR_CMP0   4

// Switch readback in the segment page
`define SEG_SW 8

`default_nettype wire

`endif

/* hdl/wb_pkg.sv */
`default_nettype none

package wb_pkg;

  // Page number from the page field of the address
  typedef logic [3:0] page_t;

  // Word offset inside a page, address bits 5 to 2
  typedef logic [3:0] word_off_t;

endpackage

`default_nettype wire

/* hdl/irq_pkg.sv */
`default_nettype none

package irq_pkg;

  typedef enum logic [3:0] {
    EXC_NONE   = 4'd0,
    EXC_BUS    = 4'd1,
    EXC_TIMER0 = 4'd4,
    EXC_TIMER1 = 4'd5,
    EXC_TIMER2 = 4'd6,
    EXC_TIMER3 = 4'd7
  } exc_code_t;

  // Raw view, segments driven straight from the word
  typedef struct packed {
    logic [14:0] rsvd_hi;
    logic        hex_mode;
    logic [7:0]  rsvd_lo;
    logic [7:0]  seg;
  } seg_raw_t;

  // Hex view, digit goes through the segment table
  typedef struct packed {
    logic [14:0] rsvd_hi;
    logic        hex_mode;
    logic [7:0]  rsvd_mid;
    logic        dp;
    logic [2:0]  rsvd_lo;
    logic [3:0]  digit;
  } seg_hex_t;

  // Bit 16 selects the view, 1 for hex
  typedef union packed {
    seg_raw_t raw;
    seg_hex_t hex;
  } seg_word_u;

endpackage

`default_nettype wire

/* hdl/wb_page_decoder.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"
`default_nettype none

module wb_page_decoder #(
  parameter int BASE = `IO_PAGE_LSB
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cyc_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [`WB_ADDR_W-1:0] adr_i,
  input  logic [`WB_DATA_W-1:0] dat_i,
  input  logic [3:0]            sel_i,
  output logic                  ack_o,
  output logic [`WB_DATA_W-1:0] dat_o,
  output logic                  seg_cyc_o,
  output logic                  seg_stb_o,
  input  logic                  seg_ack_i,
  input  logic [`WB_DATA_W-1:0] seg_dat_i,
  output logic                  tmr_cyc_o,
  output logic                  tmr_stb_o,
  input  logic                  tmr_ack_i,
  input  logic [`WB_DATA_W-1:0] tmr_dat_i,
  output logic                  bus_err_o
);
  import wb_pkg::*;

  page_t                  page;
  logic                   seg_hit;
  logic                   tmr_hit;
  logic                   err_ack_q;
  logic [`WB_DATA_W-1:0]  lane_src;

  assign page    = adr_i[BASE +: $bits(page_t)];
  assign seg_hit = (page == page_t'(`SEG_PAGE));
  assign tmr_hit = (page == page_t'(`TIMER_PAGE));

  assign seg_cyc_o = cyc_i & seg_hit;
  assign seg_stb_o = stb_i & seg_hit;
  assign tmr_cyc_o = cyc_i & tmr_hit;
  assign tmr_stb_o = stb_i & tmr_hit;

  // Nobody lives on this page, answer it ourselves
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= cyc_i && stb_i && !seg_hit && !tmr_hit && !err_ack_q;
    end
  end

  assign bus_err_o = err_ack_q;

  always_comb begin
    if (seg_hit) begin
      ack_o    = seg_ack_i;
      lane_src = we_i ? dat_i : seg_dat_i;
    end else if (tmr_hit) begin
      ack_o    = tmr_ack_i;
      lane_src = we_i ? dat_i : tmr_dat_i;
    end else begin
      ack_o    = err_ack_q;
      lane_src = '0;
    end
  end

  // Write acks echo the accepted lanes, unselected lanes read as zero
  always_comb begin
    for (int b = 0; b < `WB_DATA_W / 8; b++) begin
      dat_o[8*b +: 8] = sel_i[b] ? lane_src[8*b +: 8] : 8'h00;
    end
  end

endmodule

`default_nettype wire

/* hdl/timer_int.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"
`default_nettype none

module timer_int (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cyc_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  wb_pkg::word_off_t     adr_i,
  input  logic [`WB_DATA_W-1:0] dat_i,
  output logic                  ack_o,
  output logic [`WB_DATA_W-1:0] dat_o,
  output logic [3:0]            irq_o
);
  import wb_pkg::*;

  localparam int        NUM_CH     = 4;
  localparam word_off_t OFF_CTRL   = word_off_t'(`TMR_CTRL);
  localparam word_off_t OFF_STATUS = word_off_t'(`TMR_STATUS);
  localparam word_off_t OFF_COUNT  = word_off_t'(`TMR_COUNT);
  localparam word_off_t OFF_CMP0   = word_off_t'(`TMR_CMP0);

  logic [`WB_DATA_W-1:0] count_q;
  logic [`WB_DATA_W-1:0] cmp_q [NUM_CH];
  logic [NUM_CH-1:0]     en_q;
  logic [NUM_CH-1:0]     pend_q;
  logic [NUM_CH-1:0]     hit;
  logic [NUM_CH-1:0]     clr;
  logic                  access;
  logic                  wr;
  word_off_t             cmp_off;
  logic                  cmp_sel;
  logic [1:0]            cmp_idx;

  assign access  = cyc_i && stb_i && !ack_o;
  assign wr      = access && we_i;
  assign cmp_off = adr_i - OFF_CMP0;
  assign cmp_sel = (adr_i >= OFF_CMP0) && (cmp_off < word_off_t'(NUM_CH));
  assign cmp_idx = cmp_off[1:0];

  always_comb begin
    for (int n = 0; n < NUM_CH; n++) begin
      hit[n] = en_q[n] && (count_q == cmp_q[n]);
    end
  end

  // Write one to clear
  assign clr = (wr && adr_i == OFF_STATUS) ? dat_i[NUM_CH-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_o   <= 1'b0;
      en_q    <= '0;
      pend_q  <= '0;
      count_q <= '0;
    end else begin
      ack_o  <= access;
      pend_q <= (pend_q & ~clr) | hit;
      if (wr && adr_i == OFF_CTRL) begin
        en_q <= dat_i[NUM_CH-1:0];
      end
      if (wr && adr_i == OFF_COUNT) begin
        count_q <= dat_i;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr && cmp_sel) begin
      cmp_q[cmp_idx] <= dat_i;
    end
  end

  always_comb begin
    dat_o = '0;
    if (adr_i == OFF_CTRL) begin
      dat_o[NUM_CH-1:0] = en_q;
    end else if (adr_i == OFF_STATUS) begin
      dat_o[NUM_CH-1:0] = pend_q;
    end else if (adr_i == OFF_COUNT) begin
      dat_o = count_q;
    end else if (cmp_sel) begin
      dat_o = cmp_q[cmp_idx];
    end
  end

  assign irq_o = pend_q;

endmodule

`default_nettype wire

/* hdl/seg_ctrl.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"
`default_nettype none

module seg_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cyc_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  wb_pkg::word_off_t     adr_i,
  input  logic [`WB_DATA_W-1:0] dat_i,
  output logic                  ack_o,
  output logic [`WB_DATA_W-1:0] dat_o,
  input  logic [9:0]            sw_i,
  output logic [7:0]            hex0_o,
  output logic [7:0]            hex1_o,
  output logic [7:0]            hex2_o,
  output logic [7:0]            hex3_o,
  output logic [7:0]            hex4_o,
  output logic [7:0]            hex5_o
);
  import wb_pkg::*;
  import irq_pkg::*;

  localparam int        NUM_DIGITS = 6;
  localparam word_off_t OFF_SW     = word_off_t'(`SEG_SW);

  seg_word_u  digit_q [NUM_DIGITS];
  logic [7:0] hex_w [NUM_DIGITS];
  logic       access;

  // Segment order gfedcba, active high
  function automatic logic [6:0] hex_to_seg(input logic [3:0] digit);
    case (digit)
      4'h0: return 7'h3f;
      4'h1: return 7'h06;
      4'h2: return 7'h5b;
      4'h3: return 7'h4f;
      4'h4: return 7'h66;
      4'h5: return 7'h6d;
      4'h6: return 7'h7d;
      4'h7: return 7'h07;
      4'h8: return 7'h7f;
      4'h9: return 7'h6f;
      4'ha: return 7'h77;
      4'hb: return 7'h7c;
      4'hc: return 7'h39;
      4'hd: return 7'h5e;
      4'he: return 7'h79;
      default: return 7'h71;
    endcase
  endfunction

  // Display pins are active low
  function automatic logic [7:0] drive_digit(input seg_word_u w);
    logic [7:0] lit;
    if (w.hex.hex_mode) begin
      lit = {w.hex.dp, hex_to_seg(w.hex.digit)};
    end else begin
      lit = w.raw.seg;
    end
    return ~lit;
  endfunction

  assign access = cyc_i && stb_i && !ack_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
      for (int d = 0; d < NUM_DIGITS; d++) begin
        digit_q[d] <= '0;
      end
    end else begin
      ack_o <= access;
      for (int d = 0; d < NUM_DIGITS; d++) begin
        if (access && we_i && adr_i == word_off_t'(d)) begin
          digit_q[d] <= dat_i;
        end
      end
    end
  end

  always_comb begin
    dat_o = '0;
    if (adr_i == OFF_SW) begin
      dat_o = {{(`WB_DATA_W - 10){1'b0}}, sw_i};
    end
    for (int d = 0; d < NUM_DIGITS; d++) begin
      if (adr_i == word_off_t'(d)) begin
        dat_o = digit_q[d];
      end
    end
  end

  for (genvar d = 0; d < NUM_DIGITS; d++) begin : g_digit
    assign hex_w[d] = drive_digit(digit_q[d]);
  end

  assign hex0_o = hex_w[0];
  assign hex1_o = hex_w[1];
  assign hex2_o = hex_w[2];
  assign hex3_o = hex_w[3];
  assign hex4_o = hex_w[4];
  assign hex5_o = hex_w[5];

endmodule

`default_nettype wire

/* hdl/int_encoder.sv */
`timescale 1ns/10ps
`default_nettype none

module int_encoder (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               bus_err_i,
  input  logic [3:0]         timer_i,
  input  logic               enabled_i,
  output irq_pkg::exc_code_t exception_o
);
  import irq_pkg::*;

  exc_code_t next_code;

  // Bus error first, then timer 0 down to timer 3
  always_comb begin
    next_code = EXC_NONE;
    if (bus_err_i) begin
      next_code = EXC_BUS;
    end else if (timer_i[0]) begin
      next_code = EXC_TIMER0;
    end else if (timer_i[1]) begin
      next_code = EXC_TIMER1;
    end else if (timer_i[2]) begin
      next_code = EXC_TIMER2;
    end else if (timer_i[3]) begin
      next_code = EXC_TIMER3;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exception_o <= EXC_NONE;
    end else if (enabled_i) begin
      exception_o <= next_code;
    end else begin
      exception_o <= EXC_NONE;
    end
  end

endmodule

`default_nettype wire

/* hdl/io_subsys.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"
`default_nettype none

module io_subsys (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cyc_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  logic [`WB_ADDR_W-1:0] adr_i,
  input  logic [`WB_DATA_W-1:0] dat_i,
  input  logic [3:0]            sel_i,
  output logic                  ack_o,
  output logic [`WB_DATA_W-1:0] dat_o,
  input  logic [9:0]            sw_i,
  output logic [7:0]            hex0_o,
  output logic [7:0]            hex1_o,
  output logic [7:0]            hex2_o,
  output logic [7:0]            hex3_o,
  output logic [7:0]            hex4_o,
  output logic [7:0]            hex5_o,
  input  logic                  int_en_i,
  output irq_pkg::exc_code_t    exception_o
);

  logic                  seg_cyc;
  logic                  seg_stb;
  logic                  seg_ack;
  logic [`WB_DATA_W-1:0] seg_dat;
  logic                  tmr_cyc;
  logic                  tmr_stb;
  logic                  tmr_ack;
  logic [`WB_DATA_W-1:0] tmr_dat;
  logic                  bus_err;
  logic [3:0]            timer_irq;

  wb_page_decoder #(.BASE(`IO_PAGE_LSB)) bus_dec (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .we_i      (we_i),
    .adr_i     (adr_i),
    .dat_i     (dat_i),
    .sel_i     (sel_i),
    .ack_o     (ack_o),
    .dat_o     (dat_o),
    .seg_cyc_o (seg_cyc),
    .seg_stb_o (seg_stb),
    .seg_ack_i (seg_ack),
    .seg_dat_i (seg_dat),
    .tmr_cyc_o (tmr_cyc),
    .tmr_stb_o (tmr_stb),
    .tmr_ack_i (tmr_ack),
    .tmr_dat_i (tmr_dat),
    .bus_err_o (bus_err)
  );

  // Peripherals see the word offset only
  seg_ctrl seg0 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .cyc_i  (seg_cyc),
    .stb_i  (seg_stb),
    .we_i   (we_i),
    .adr_i  (adr_i[5:2]),
    .dat_i  (dat_i),
    .ack_o  (seg_ack),
    .dat_o  (seg_dat),
    .sw_i   (sw_i),
    .hex0_o (hex0_o),
    .hex1_o (hex1_o),
    .hex2_o (hex2_o),
    .hex3_o (hex3_o),
    .hex4_o (hex4_o),
    .hex5_o (hex5_o)
  );

  timer_int timer0 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cyc_i (tmr_cyc),
    .stb_i (tmr_stb),
    .we_i  (we_i),
    .adr_i (adr_i[5:2]),
    .dat_i (dat_i),
    .ack_o (tmr_ack),
    .dat_o (tmr_dat),
    .irq_o (timer_irq)
  );

  int_encoder intenc0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_err_i   (bus_err),
    .timer_i     (timer_irq),
    .enabled_i   (int_en_i),
    .exception_o (exception_o)
  );

endmodule

`default_nettype wire

/* dv/io_subsys_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module io_subsys_sva (
  input logic               clk_i,
  input logic               rst_i,
  input logic               stb_i,
  input logic               ack_i,
  input logic               enabled_i,
  input irq_pkg::exc_code_t exception_i
);
  import irq_pkg::*;

  a_ack_needs_stb: assert property (
    @(posedge clk_i) disable iff (rst_i) ack_i |-> stb_i
  ) else $error("ack seen while stb is low");

  // Classic cycle, one ack pulse per strobe
  a_ack_single: assert property (
    @(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i
  ) else $error("ack held longer than one cycle");

  a_exc_gated: assert property (
    @(posedge clk_i) disable iff (rst_i) !enabled_i |=> (exception_i == EXC_NONE)
  ) else $error("exception raised after interrupts were disabled");

  a_quiet_in_reset: assert property (
    @(posedge clk_i) rst_i |=> (!ack_i && exception_i == EXC_NONE)
  ) else $error("ack or exception active during reset");

endmodule

// Decoder side has no exception, encoder side has no bus
bind wb_page_decoder io_subsys_sva bus_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .stb_i       (stb_i),
  .ack_i       (ack_o),
  .enabled_i   (1'b1),
  .exception_i (irq_pkg::EXC_NONE)
);

bind int_encoder io_subsys_sva irq_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .stb_i       (1'b1),
  .ack_i       (1'b0),
  .enabled_i   (enabled_i),
  .exception_i (exception_o)
);

`default_nettype wire

/* dv/io_subsys_tb.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"
`default_nettype none

module clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);
  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

module io_subsys_tb;
  import irq_pkg::*;

  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
  localparam int          ACK_TIMEOUT = 20;
  // Active high segments in gfedcba order
  localparam logic [6:0] GLYPHS [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                                         7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

  logic        clk_i;
  logic        rst_i;
  logic        cyc_i;
  logic        stb_i;
  logic        we_i;
  logic [31:0] adr_i;
  logic [31:0] dat_i;
  logic [3:0]  sel_i;
  logic        ack_o;
  logic [31:0] dat_o;
  logic [9:0]  sw_i;
  logic [7:0]  hex_w [6];
  logic        int_en_i;
  exc_code_t   exception_o;

  logic [31:0] lfsr_q = 32'd34;
  int          mismatch_cnt = 0;
  int          error_cnt = 0;
  string       name_q [$];
  logic [31:0] exp_q [$];
  logic [31:0] act_q [$];

  clk_gen #(.PERIOD_NS(20)) clkgen0 (.clk_o(clk_i));

  io_subsys dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cyc_i       (cyc_i),
    .stb_i       (stb_i),
    .we_i        (we_i),
    .adr_i       (adr_i),
    .dat_i       (dat_i),
    .sel_i       (sel_i),
    .ack_o       (ack_o),
    .dat_o       (dat_o),
    .sw_i        (sw_i),
    .hex0_o      (hex_w[0]),
    .hex1_o      (hex_w[1]),
    .hex2_o      (hex_w[2]),
    .hex3_o      (hex_w[3]),
    .hex4_o      (hex_w[4]),
    .hex5_o      (hex_w[5]),
    .int_en_i    (int_en_i),
    .exception_o (exception_o)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // Expected pins are active low and bit 16 picks hex mode
  function automatic logic [7:0] seg_ref(input logic [31:0] w);
    if (w[16]) begin
      return ~{w[7], GLYPHS[w[3:0]]};
    end
    return ~w[7:0];
  endfunction

  function automatic logic [3:0] exc_ref(input logic bus_err, input logic [3:0] timers,
                                         input logic enabled);
    logic [3:0] code;
    code = 4'(EXC_NONE);
    if (enabled && bus_err) begin
      code = 4'(EXC_BUS);
    end else if (enabled) begin
      // Lowest channel is looked at last so it wins
      for (int n = 3; n >= 0; n--) begin
        if (timers[n]) begin
          code = 4'(EXC_TIMER0) + 4'(n);
        end
      end
    end
    return code;
  endfunction

  function automatic logic [31:0] ack_data_ref(input logic mapped, input logic [3:0] sel,
                                               input logic [31:0] word);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return mapped ? (word & mask) : 32'd0;
  endfunction

  function automatic logic [31:0] page_addr(input int page, input int off);
    return (32'(page) << `IO_PAGE_LSB) | (32'(off) << 2);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      mismatch_cnt++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic post_check(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    name_q.push_back(name);
    exp_q.push_back(expected);
    act_q.push_back(actual);
  endtask

  always @(posedge clk_i) begin
    while (name_q.size() != 0) begin
      check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  task automatic bus_start(input logic we, input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= we;
    adr_i <= addr;
    dat_i <= data;
    sel_i <= 4'hf;
  endtask

  task automatic wait_ack(input logic [31:0] addr, output logic [31:0] rdata);
    logic got;
    got = 1'b0;
    rdata = '0;
    for (int i = 0; i < ACK_TIMEOUT && !got; i++) begin
      @(negedge clk_i);
      if (ack_o) begin
        got = 1'b1;
        rdata = dat_o;
      end
    end
    if (!got) begin
      error_cnt++;
      $display("Timeout: no ack for the access to address %h", addr);
    end
  endtask

  task automatic bus_stop();
    @(posedge clk_i);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] echo;
    bus_start(1'b1, addr, data);
    wait_ack(addr, echo);
    post_check($sformatf("write echo %h", addr), ack_data_ref(1'b1, 4'hf, data), echo);
    bus_stop();
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_start(1'b0, addr, 32'd0);
    wait_ack(addr, data);
    bus_stop();
  endtask

  task automatic wait_code(input logic [3:0] code, input int limit, input string what);
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < limit && !seen; i++) begin
      @(negedge clk_i);
      seen = (4'(exception_o) == code);
    end
    if (!seen) begin
      error_cnt++;
      $display("Timeout: exception code %0d never showed up for %s", code, what);
    end
  endtask

  initial begin
    repeat (40000) @(posedge clk_i);
    $display("Watchdog expired before the tests completed");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] w;
    logic [31:0] mode;
    logic [31:0] cnt;
    logic [31:0] words [6];
    logic        seen;
    rst_i    = 1'b1;
    cyc_i    = 1'b0;
    stb_i    = 1'b0;
    we_i     = 1'b0;
    adr_i    = '0;
    dat_i    = '0;
    sel_i    = 4'h0;
    sw_i     = '0;
    int_en_i = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_i    <= 1'b0;
    int_en_i <= 1'b1;

    // Display writes in both modes
    for (int d = 0; d < 6; d++) begin
      take_bits(1, mode);
      take_bits(32, w);
      w[16] = mode[0];
      bus_write(page_addr(`SEG_PAGE, d), w);
      @(negedge clk_i);
      post_check($sformatf("digit %0d segments", d), {24'd0, seg_ref(w)}, {24'd0, hex_w[d]});
      bus_read(page_addr(`SEG_PAGE, d), rd);
      post_check($sformatf("digit %0d readback", d), ack_data_ref(1'b1, 4'hf, w), rd);
    end

    repeat (4) begin
      take_bits(10, w);
      @(posedge clk_i);
      sw_i <= w[9:0];
      bus_read(page_addr(`SEG_PAGE, `SEG_SW), rd);
      post_check("switch readback", ack_data_ref(1'b1, 4'hf, {22'd0, w[9:0]}), rd);
    end

    // One compare channel at a time
    for (int n = 0; n < 4; n++) begin
      bus_read(page_addr(`TIMER_PAGE, `TMR_COUNT), cnt);
      bus_write(page_addr(`TIMER_PAGE, `TMR_CMP0 + n), cnt + 32'd40);
      bus_write(page_addr(`TIMER_PAGE, `TMR_CTRL), 32'd1 << n);
      wait_code(exc_ref(1'b0, 4'(1 << n), 1'b1), 200, $sformatf("timer %0d", n));
      bus_read(page_addr(`TIMER_PAGE, `TMR_STATUS), rd);
      post_check($sformatf("timer %0d status", n), ack_data_ref(1'b1, 4'hf, 32'd1 << n), rd);
      bus_write(page_addr(`TIMER_PAGE, `TMR_STATUS), 32'd1 << n);
      wait_code(exc_ref(1'b0, 4'b0000, 1'b1), 10, "pending clear");
    end

    // Channels 0 and 2 fire together
    bus_read(page_addr(`TIMER_PAGE, `TMR_COUNT), cnt);
    bus_write(page_addr(`TIMER_PAGE, `TMR_CMP0), cnt + 32'd40);
    bus_write(page_addr(`TIMER_PAGE, `TMR_CMP0 + 2), cnt + 32'd40);
    bus_write(page_addr(`TIMER_PAGE, `TMR_CTRL), 32'h5);
    for (int i = 0; i < 200 && exception_o == EXC_NONE; i++) begin
      @(negedge clk_i);
    end
    if (exception_o == EXC_NONE) begin
      error_cnt++;
      $display("Timeout: timers 0 and 2 raised no exception");
    end
    @(negedge clk_i);
    post_check("priority timer 0 over 2", 32'(exc_ref(1'b0, 4'b0101, 1'b1)), 32'(exception_o));
    bus_read(page_addr(`TIMER_PAGE, `TMR_STATUS), rd);
    post_check("priority status", ack_data_ref(1'b1, 4'hf, 32'h5), rd);
    @(posedge clk_i);
    int_en_i <= 1'b0;
    repeat (2) @(negedge clk_i);
    post_check("masked exception", 32'(exc_ref(1'b0, 4'b0101, 1'b0)), 32'(exception_o));
    @(posedge clk_i);
    int_en_i <= 1'b1;
    bus_write(page_addr(`TIMER_PAGE, `TMR_STATUS), 32'h5);
    bus_write(page_addr(`TIMER_PAGE, `TMR_CTRL), 32'h0);
    wait_code(exc_ref(1'b0, 4'b0000, 1'b1), 10, "priority clear");

    // Page 3 has no slave
    bus_read(page_addr(3, 0), rd);
    post_check("unmapped read data", ack_data_ref(1'b0, 4'hf, 32'hffff_ffff), rd);
    seen = 1'b0;
    repeat (4) begin
      @(negedge clk_i);
      if (4'(exception_o) == exc_ref(1'b1, 4'b0000, 1'b1)) begin
        seen = 1'b1;
      end
    end
    post_check("unmapped bus error", 32'd1, {31'd0, seen});

    // stb stays high across all six writes
    for (int d = 0; d < 6; d++) begin
      take_bits(32, words[d]);
      bus_start(1'b1, page_addr(`SEG_PAGE, d), words[d]);
      wait_ack(page_addr(`SEG_PAGE, d), rd);
    end
    bus_stop();
    for (int d = 0; d < 6; d++) begin
      bus_read(page_addr(`SEG_PAGE, d), rd);
      post_check($sformatf("burst digit %0d", d), ack_data_ref(1'b1, 4'hf, words[d]), rd);
    end

    for (int i = 0; i < 10 && name_q.size() != 0; i++) begin
      @(negedge clk_i);
    end
    if (name_q.size() != 0) begin
      error_cnt++;
      $display("Compare process left %0d checks unprocessed", name_q.size());
    end
    $display("Finished with %0d mismatches and %0d other errors", mismatch_cnt, error_cnt);
    if (mismatch_cnt == 0 && error_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* io_subsys.f */
+incdir+hdl
hdl/wb_pkg.sv
hdl/irq_pkg.sv
hdl/wb_page_decoder.sv
hdl/timer_int.sv
hdl/seg_ctrl.sv
hdl/int_encoder.sv
hdl/io_subsys.sv
dv/io_subsys_sva.sv
dv/io_subsys_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = io_subsys_tb
FILELIST = io_subsys.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
